/* Bender.yml */
package:
  name: cpu

sources:
  - common/cpu_pkg.sv
  - control/cpu_decode.sv
  - control/cpu_sequencer.sv
  - datapath/cpu_alu.sv
  - datapath/cpu_regs.sv
  - source/cpu.sv
  - target: test
    files:
      - tests/cpu_assert.sv
      - tests/tb_cpu.sv

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// bus widths
	localparam int addr_width = 16;
	localparam int data_width = 8;

	// high byte of every zero page address
	localparam logic [7:0] zero_page = 8'h00;

	// addressing modes, shared by decoder and sequencer
	localparam logic [2:0] adr_impl = 3'd0;
	localparam logic [2:0] adr_imm = 3'd1;
	localparam logic [2:0] adr_zpg = 3'd2;
	localparam logic [2:0] adr_abs = 3'd3;
	localparam logic [2:0] adr_abs_jmp = 3'd4;
	localparam logic [2:0] adr_rel = 3'd5;

	// alu operations
	localparam logic [2:0] alu_pass = 3'd0;
	localparam logic [2:0] alu_add = 3'd1;
	localparam logic [2:0] alu_and = 3'd2;
	localparam logic [2:0] alu_or = 3'd3;
	localparam logic [2:0] alu_eor = 3'd4;
	localparam logic [2:0] alu_cmp = 3'd5;
	localparam logic [2:0] alu_inc = 3'd6;
	localparam logic [2:0] alu_dec = 3'd7;

	// register selects
	localparam logic [1:0] reg_none = 2'd0;
	localparam logic [1:0] reg_a = 2'd1;
	localparam logic [1:0] reg_x = 2'd2;
	localparam logic [1:0] reg_y = 2'd3;

	// status byte layout: N V 1 1 1 1 Z C
	localparam logic [2:0] flag_n = 3'd7;
	localparam logic [2:0] flag_v = 3'd6;
	localparam logic [2:0] flag_z = 3'd1;
	localparam logic [2:0] flag_c = 3'd0;

	// opcode as raw byte or as aaa/bbb/cc fields
	typedef struct packed {
		logic [2:0] aaa;
		logic [2:0] bbb;
		logic [1:0] cc;
	} opcode_fields_t;

	typedef union packed {
		logic [7:0] raw;
		opcode_fields_t f;
	} opcode_u;

endpackage

`default_nettype wire

/* compile.f */
common/cpu_pkg.sv
control/cpu_decode.sv
control/cpu_sequencer.sv
datapath/cpu_alu.sv
datapath/cpu_regs.sv
source/cpu.sv
tests/cpu_assert.sv
tests/tb_cpu.sv

/* control/cpu_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_decode
	import cpu_pkg::*;
(
	input wire opcode_u opcode,
	output logic [2:0] adr_mode,
	output logic [2:0] alu_op,
	output logic [1:0] src_sel,
	output logic [1:0] dst_sel,
	output logic mem_store,
	output logic upd_nz,
	output logic upd_c,
	output logic upd_v,
	output logic clr_c,
	output logic set_c,
	output logic [2:0] branch_flag,
	output logic branch_value
);

	logic [2:0] grp_mode;
	logic grp_valid;

	// mode from bbb, group 01 differs from groups 00 and 10
	always_comb
	begin
		grp_mode = adr_impl;
		grp_valid = 1'b1;
		case ({opcode.f.cc == 2'b01, opcode.f.bbb})
			{1'b1, 3'b001}: grp_mode = adr_zpg;
			{1'b1, 3'b010}: grp_mode = adr_imm;
			{1'b1, 3'b011}: grp_mode = adr_abs;
			{1'b0, 3'b000}: grp_mode = adr_imm;
			{1'b0, 3'b001}: grp_mode = adr_zpg;
			{1'b0, 3'b011}: grp_mode = adr_abs;
			default: grp_valid = 1'b0;
		endcase
	end

	always_comb
	begin
		// anything unknown falls through as a two cycle nop
		adr_mode = adr_impl;
		alu_op = alu_pass;
		src_sel = reg_none;
		dst_sel = reg_none;
		mem_store = 1'b0;
		upd_nz = 1'b0;
		upd_c = 1'b0;
		upd_v = 1'b0;
		clr_c = 1'b0;
		set_c = 1'b0;
		branch_flag = flag_c;
		branch_value = 1'b0;
		case (opcode.raw)
			8'h18: clr_c = 1'b1;
			8'h38: set_c = 1'b1;
			8'haa:
			begin
				src_sel = reg_a;
				dst_sel = reg_x;
				upd_nz = 1'b1;
			end
			8'h8a:
			begin
				src_sel = reg_x;
				dst_sel = reg_a;
				upd_nz = 1'b1;
			end
			8'he8, 8'hca:
			begin
				alu_op = opcode.raw[5] ? alu_inc : alu_dec;
				src_sel = reg_x;
				dst_sel = reg_x;
				upd_nz = 1'b1;
			end
			8'hc8, 8'h88:
			begin
				alu_op = opcode.raw[6] ? alu_inc : alu_dec;
				src_sel = reg_y;
				dst_sel = reg_y;
				upd_nz = 1'b1;
			end
			8'h4c: adr_mode = adr_abs_jmp;
			// bit 6 picks zero over carry, bit 5 is the wanted value
			8'h90, 8'hb0, 8'hd0, 8'hf0:
			begin
				adr_mode = adr_rel;
				branch_flag = opcode.raw[6] ? flag_z : flag_c;
				branch_value = opcode.raw[5];
			end
			default:
			if (grp_valid)
				case ({opcode.f.cc, opcode.f.aaa})
					{2'b01, 3'b000}, {2'b01, 3'b001}, {2'b01, 3'b010}, {2'b01, 3'b011}:
					begin
						adr_mode = grp_mode;
						src_sel = reg_a;
						dst_sel = reg_a;
						upd_nz = 1'b1;
						case (opcode.f.aaa)
							3'b000: alu_op = alu_or;
							3'b001: alu_op = alu_and;
							3'b010: alu_op = alu_eor;
							default:
							begin
								alu_op = alu_add;
								upd_c = 1'b1;
								upd_v = 1'b1;
							end
						endcase
					end
					{2'b01, 3'b110}:
					begin
						adr_mode = grp_mode;
						alu_op = alu_cmp;
						src_sel = reg_a;
						upd_nz = 1'b1;
						upd_c = 1'b1;
					end
					{2'b01, 3'b101}, {2'b10, 3'b101}, {2'b00, 3'b101}:
					begin
						adr_mode = grp_mode;
						dst_sel = opcode.f.cc[0] ? reg_a : (opcode.f.cc[1] ? reg_x : reg_y);
						upd_nz = 1'b1;
					end
					// stores have no immediate form
					{2'b01, 3'b100}, {2'b10, 3'b100}, {2'b00, 3'b100}:
					if (grp_mode != adr_imm)
					begin
						adr_mode = grp_mode;
						src_sel = opcode.f.cc[0] ? reg_a : (opcode.f.cc[1] ? reg_x : reg_y);
						mem_store = 1'b1;
					end
					default: ;
				endcase
		endcase
	end

endmodule

`default_nettype wire

/* control/cpu_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_sequencer
	import cpu_pkg::*;
#(
	parameter logic [addr_width-1:0] reset_vector = 16'h8000
)
(
	input wire clk,
	input wire n_reset,
	input wire [data_width-1:0] data_in,
	input wire [2:0] adr_mode,
	input wire mem_store,
	input wire [2:0] branch_flag,
	input wire branch_value,
	input wire [data_width-1:0] flags,
	input wire [data_width-1:0] store_value,
	output opcode_u ir,
	output logic [addr_width-1:0] adr,
	output logic rw,
	output logic [data_width-1:0] data_out,
	output logic sync,
	output logic [addr_width-1:0] pc,
	output logic latch_operand,
	output logic writeback
);

	logic [2:0] state;
	logic [7:0] oper_low;
	logic pending;
	logic [addr_width-1:0] pc_next;
	logic taken;
	logic store_start;
	logic [8:0] rel_sum;
	logic [7:0] rel_high;

	assign pc_next = pc + 16'd1;
	assign sync = (state == 3'd0);
	assign writeback = sync && pending;
	assign taken = (flags[branch_flag] == branch_value);

	// store goes out on the last cycle of zpg and abs
	assign store_start = mem_store && (((adr_mode == adr_zpg) && (state == 3'd1))
		|| ((adr_mode == adr_abs) && (state == 3'd2)));

	// operands are taken in the execute cycle
	always_comb
	begin
		case (adr_mode)
			adr_impl, adr_imm: latch_operand = (state == 3'd1);
			adr_zpg: latch_operand = (state == 3'd2) && !mem_store;
			adr_abs: latch_operand = (state == 3'd3) && !mem_store;
			default: latch_operand = 1'b0;
		endcase
	end

	// branch target, pc already points past the offset
	always_comb
	begin
		rel_sum = {1'b0, pc[7:0]} + {1'b0, oper_low};
		rel_high = pc[15:8];
		if (oper_low[7] && !rel_sum[8])
			rel_high = pc[15:8] - 8'd1;
		else if (!oper_low[7] && rel_sum[8])
			rel_high = pc[15:8] + 8'd1;
	end

	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			state <= 3'd0;
			pc <= reset_vector;
			adr <= reset_vector;
			rw <= 1'b1;
			ir.raw <= 8'h00;
			oper_low <= 8'h00;
			pending <= 1'b0;
		end
		else
		begin
			pending <= latch_operand;
			if (store_start)
				rw <= 1'b0;
			if (state == 3'd0)
			begin
				ir.raw <= data_in;
				pc <= pc_next;
				adr <= pc_next;
				state <= 3'd1;
			end
			else
			begin
				case (adr_mode)
					adr_imm:
					begin
						pc <= pc_next;
						adr <= pc_next;
						state <= 3'd0;
					end
					adr_zpg:
					if (state == 3'd1)
					begin
						pc <= pc_next;
						adr <= {zero_page, data_in};
						state <= 3'd2;
					end
					else
					begin
						adr <= pc;
						rw <= 1'b1;
						state <= 3'd0;
					end
					adr_abs, adr_abs_jmp:
					if (state == 3'd1)
					begin
						oper_low <= data_in;
						pc <= pc_next;
						adr <= pc_next;
						state <= 3'd2;
					end
					else if (adr_mode == adr_abs_jmp)
					begin
						pc <= {data_in, oper_low};
						adr <= {data_in, oper_low};
						state <= 3'd0;
					end
					else if (state == 3'd2)
					begin
						pc <= pc_next;
						adr <= {data_in, oper_low};
						state <= 3'd3;
					end
					else
					begin
						adr <= pc;
						rw <= 1'b1;
						state <= 3'd0;
					end
					adr_rel:
					if (state == 3'd1)
					begin
						oper_low <= data_in;
						pc <= pc_next;
						adr <= pc_next;
						state <= taken ? 3'd2 : 3'd0;
					end
					else
					begin
						pc <= {rel_high, rel_sum[7:0]};
						adr <= {rel_high, rel_sum[7:0]};
						state <= 3'd0;
					end
					default:
					begin
						adr <= pc;
						state <= 3'd0;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (store_start)
			data_out <= store_value;
	end

endmodule

`default_nettype wire

/* datapath/cpu_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_alu
	import cpu_pkg::*;
(
	input wire [2:0] op,
	input wire carry_in,
	input wire [data_width-1:0] a,
	input wire [data_width-1:0] b,
	output logic [data_width-1:0] result,
	output logic n,
	output logic v,
	output logic z,
	output logic c
);

	logic [data_width:0] sum;
	logic [data_width:0] diff;

	assign sum = {1'b0, a} + {1'b0, b} + {{data_width{1'b0}}, carry_in};

	// borrow out of bit 8 means a < b
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb
	begin
		result = b;
		c = carry_in;
		v = 1'b0;
		case (op)
			alu_add:
			begin
				result = sum[data_width-1:0];
				c = sum[data_width];
				// signed overflow, same input signs but result sign differs
				v = (a[data_width-1] == b[data_width-1])
					&& (result[data_width-1] != a[data_width-1]);
			end
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_eor: result = a ^ b;
			alu_cmp:
			begin
				result = diff[data_width-1:0];
				c = !diff[data_width];
			end
			alu_inc: result = b + 1'b1;
			alu_dec: result = b - 1'b1;
			default: result = b;
		endcase
	end

	assign n = result[data_width-1];
	assign z = (result == '0);

endmodule

`default_nettype wire

/* datapath/cpu_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_regs
	import cpu_pkg::*;
(
	input wire clk,
	input wire n_reset,
	input wire [data_width-1:0] data_in,
	input wire latch_operand,
	input wire writeback,
	input wire [2:0] alu_op,
	input wire [1:0] src_sel,
	input wire [1:0] dst_sel,
	input wire upd_nz,
	input wire upd_c,
	input wire upd_v,
	input wire clr_c,
	input wire set_c,
	input wire [data_width-1:0] alu_result,
	input wire alu_n,
	input wire alu_v,
	input wire alu_z,
	input wire alu_c,
	output logic [data_width-1:0] operand_a,
	output logic [data_width-1:0] operand_b,
	output logic [data_width-1:0] store_value,
	output logic [data_width-1:0] flags,
	output logic [data_width-1:0] a,
	output logic [data_width-1:0] x,
	output logic [data_width-1:0] y
);

	logic neg;
	logic ovf;
	logic zero;
	logic carry;
	logic unary;

	always_comb
	begin
		case (src_sel)
			reg_a: store_value = a;
			reg_x: store_value = x;
			reg_y: store_value = y;
			default: store_value = '0;
		endcase
	end

	// single operand ops work on a register, loads on the data bus
	assign unary = (alu_op == alu_pass) || (alu_op == alu_inc) || (alu_op == alu_dec);

	always_comb
	begin
		flags = 8'h3c;
		flags[flag_n] = neg;
		flags[flag_v] = ovf;
		flags[flag_z] = zero;
		flags[flag_c] = carry;
	end

	always_ff @(posedge clk)
	begin
		if (latch_operand)
		begin
			operand_a <= store_value;
			operand_b <= (unary && (src_sel != reg_none)) ? store_value : data_in;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			a <= '0;
			x <= '0;
			y <= '0;
			neg <= 1'b0;
			ovf <= 1'b0;
			zero <= 1'b0;
			carry <= 1'b0;
		end
		else if (writeback)
		begin
			case (dst_sel)
				reg_a: a <= alu_result;
				reg_x: x <= alu_result;
				reg_y: y <= alu_result;
				default: ;
			endcase
			if (upd_nz)
			begin
				neg <= alu_n;
				zero <= alu_z;
			end
			if (upd_v)
				ovf <= alu_v;
			// explicit clear and set win over the alu carry
			if (clr_c)
				carry <= 1'b0;
			else if (set_c)
				carry <= 1'b1;
			else if (upd_c)
				carry <= alu_c;
		end
	end

endmodule

`default_nettype wire

/* source/cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu
	import cpu_pkg::*;
#(
	parameter logic [addr_width-1:0] reset_vector = 16'h8000
)
(
	input wire clk,
	input wire n_reset,
	input wire [data_width-1:0] data_in,
	output logic [addr_width-1:0] adr,
	output logic rw,
	output logic [data_width-1:0] data_out,
	output logic sync,
	output logic [addr_width-1:0] dbg_pc,
	output logic [data_width-1:0] dbg_a,
	output logic [data_width-1:0] dbg_x,
	output logic [data_width-1:0] dbg_y,
	output logic [data_width-1:0] dbg_p
);

	opcode_u ir;

	// decoder outputs
	wire [2:0] adr_mode;
	wire [2:0] alu_op;
	wire [1:0] src_sel;
	wire [1:0] dst_sel;
	wire mem_store;
	wire upd_nz;
	wire upd_c;
	wire upd_v;
	wire clr_c;
	wire set_c;
	wire [2:0] branch_flag;
	wire branch_value;

	// sequencer to register file
	wire latch_operand;
	wire writeback;

	// datapath
	wire [data_width-1:0] operand_a;
	wire [data_width-1:0] operand_b;
	wire [data_width-1:0] store_value;
	wire [data_width-1:0] alu_result;
	wire alu_n;
	wire alu_v;
	wire alu_z;
	wire alu_c;

	cpu_sequencer #(
		.reset_vector(reset_vector)
	) sequencer_inst (
		.clk(clk), .n_reset(n_reset), .data_in(data_in),
		.adr_mode(adr_mode), .mem_store(mem_store),
		.branch_flag(branch_flag), .branch_value(branch_value),
		.flags(dbg_p), .store_value(store_value), .ir(ir),
		.adr(adr), .rw(rw), .data_out(data_out), .sync(sync), .pc(dbg_pc),
		.latch_operand(latch_operand), .writeback(writeback)
	);

	cpu_decode decode_inst (
		.opcode(ir), .adr_mode(adr_mode), .alu_op(alu_op),
		.src_sel(src_sel), .dst_sel(dst_sel), .mem_store(mem_store),
		.upd_nz(upd_nz), .upd_c(upd_c), .upd_v(upd_v), .clr_c(clr_c), .set_c(set_c),
		.branch_flag(branch_flag), .branch_value(branch_value)
	);

	cpu_regs regs_inst (
		.clk(clk), .n_reset(n_reset), .data_in(data_in),
		.latch_operand(latch_operand), .writeback(writeback),
		.alu_op(alu_op), .src_sel(src_sel), .dst_sel(dst_sel),
		.upd_nz(upd_nz), .upd_c(upd_c), .upd_v(upd_v), .clr_c(clr_c), .set_c(set_c),
		.alu_result(alu_result), .alu_n(alu_n), .alu_v(alu_v), .alu_z(alu_z),
		.alu_c(alu_c), .operand_a(operand_a), .operand_b(operand_b),
		.store_value(store_value), .flags(dbg_p), .a(dbg_a), .x(dbg_x), .y(dbg_y)
	);

	cpu_alu alu_inst (
		.op(alu_op), .carry_in(dbg_p[flag_c]), .a(operand_a), .b(operand_b),
		.result(alu_result), .n(alu_n), .v(alu_v), .z(alu_z), .c(alu_c)
	);

endmodule

`default_nettype wire

/* tests/cpu_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_assert
(
	input wire clk,
	input wire n_reset,
	input wire sync,
	input wire rw,
	input wire [15:0] adr
);

	// number of failed checks
	int fail_cnt = 0;

	// an opcode fetch is always a read
	no_write_on_fetch: assert property (@(posedge clk) disable iff (!n_reset)
		sync |-> rw)
	else
	begin
		$error("write cycle during an opcode fetch");
		fail_cnt++;
	end

	// stores last exactly one bus cycle
	single_write_cycle: assert property (@(posedge clk) disable iff (!n_reset)
		!rw |=> rw)
	else
	begin
		$error("write cycle longer than one clock");
		fail_cnt++;
	end

	adr_known: assert property (@(posedge clk) disable iff (!n_reset)
		!$isunknown(adr))
	else
	begin
		$error("address bus unknown after reset");
		fail_cnt++;
	end

endmodule

bind cpu cpu_assert cpu_assert_inst (
	.clk(clk),
	.n_reset(n_reset),
	.sync(sync),
	.rw(rw),
	.adr(adr)
);

`default_nettype wire

/* tests/tb_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

	localparam int max_len = 512;

	logic clk;
	logic n_reset;
	wire [7:0] data_in;
	logic [15:0] adr;
	logic rw;
	logic [7:0] data_out;
	logic sync;
	logic [15:0] dbg_pc;
	logic [7:0] dbg_a;
	logic [7:0] dbg_x;
	logic [7:0] dbg_y;
	logic [7:0] dbg_p;

	logic [7:0] mem [0:65535];

	// reference model state
	logic [15:0] pc;
	logic [7:0] ra;
	logic [7:0] rx;
	logic [7:0] ry;
	logic fn;
	logic fv;
	logic fz;
	logic fc;
	logic [7:0] ref_mem [logic [15:0]];
	logic [31:0] lcg_state;

	// expected fetches, gaps, register snapshots and stores
	logic [15:0] exp_fetch [0:max_len-1];
	int exp_gap [0:max_len-1];
	logic [7:0] exp_a [0:max_len];
	logic [7:0] exp_x [0:max_len];
	logic [7:0] exp_y [0:max_len];
	logic [7:0] exp_p [0:max_len];
	logic [15:0] exp_store_adr [0:63];
	logic [7:0] exp_store_val [0:63];

	int n_fetch = 0;
	int n_store = 0;
	int total_cycles = 0;
	int cycle_limit = 0;
	int cycle_cnt = 0;
	int fetch_cnt = 0;
	int store_cnt = 0;
	int since_fetch = 0;

	cpu #(
		.reset_vector(16'h8000)
	) cpu_inst (
		.clk(clk), .n_reset(n_reset), .data_in(data_in),
		.adr(adr), .rw(rw), .data_out(data_out), .sync(sync),
		.dbg_pc(dbg_pc), .dbg_a(dbg_a), .dbg_x(dbg_x), .dbg_y(dbg_y), .dbg_p(dbg_p)
	);

	// memory answers in the same cycle
	assign data_in = mem[adr];

	initial
		clk = 1'b0;

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		if (!rw)
			mem[adr] <= data_out;
	end

	task report_fail;
		$display("TB FAILED");
		$fatal(1);
	endtask

	function logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	function logic [7:0] fill_byte(input logic [15:0] a);
		return a[15:8] ^ a[7:0] ^ 8'ha5;
	endfunction

	function logic [7:0] ref_read(input logic [15:0] a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
	endfunction

	task put(input logic [15:0] a, input logic [7:0] b);
		mem[a] = b;
	endtask

	task open_instr(input int cycles);
		exp_fetch[n_fetch] = pc;
		exp_gap[n_fetch] = cycles;
		total_cycles += cycles;
		n_fetch++;
	endtask

	// snapshot index is the number of instructions done
	task close_instr;
		exp_a[n_fetch] = ra;
		exp_x[n_fetch] = rx;
		exp_y[n_fetch] = ry;
		exp_p[n_fetch] = {fn, fv, 4'b1111, fz, fc};
	endtask

	task set_nz(input logic [7:0] r);
		fn = r[7];
		fz = (r == 8'h00);
	endtask

	task apply_operand(input logic [7:0] opc, input logic [7:0] val);
		logic [8:0] sum;
		logic [8:0] diff;
		sum = {1'b0, ra} + {1'b0, val} + {8'h00, fc};
		diff = {1'b0, ra} - {1'b0, val};
		case (opc)
			8'ha9, 8'ha5, 8'had: ra = val;
			8'ha2, 8'ha6, 8'hae: rx = val;
			8'ha0, 8'ha4, 8'hac: ry = val;
			8'h29: ra = ra & val;
			8'h09: ra = ra | val;
			8'h49: ra = ra ^ val;
			8'h69:
			begin
				fv = (ra[7] == val[7]) && (sum[7] != ra[7]);
				fc = sum[8];
				ra = sum[7:0];
			end
			default: fc = (ra >= val);
		endcase
		if (opc == 8'hc9)
			set_nz(diff[7:0]);
		else
			set_nz(opc[1] ? rx : (opc[0] ? ra : ry));
	endtask

	task imm(input logic [7:0] opc, input logic [7:0] val);
		open_instr(2);
		put(pc, opc);
		put(pc + 16'd1, val);
		pc = pc + 16'd2;
		apply_operand(opc, val);
		close_instr();
	endtask

	task load_abs(input logic [7:0] opc, input logic [15:0] a);
		open_instr(4);
		put(pc, opc);
		put(pc + 16'd1, a[7:0]);
		put(pc + 16'd2, a[15:8]);
		pc = pc + 16'd3;
		apply_operand(opc, ref_read(a));
		close_instr();
	endtask

	// bit 3 of the opcode selects absolute over zero page
	task store(input logic [7:0] opc, input logic [15:0] a);
		logic [7:0] val;
		val = opc[1] ? rx : (opc[0] ? ra : ry);
		open_instr(opc[3] ? 4 : 3);
		put(pc, opc);
		put(pc + 16'd1, a[7:0]);
		if (opc[3])
			put(pc + 16'd2, a[15:8]);
		pc = pc + (opc[3] ? 16'd3 : 16'd2);
		ref_mem[a] = val;
		exp_store_adr[n_store] = a;
		exp_store_val[n_store] = val;
		n_store++;
		close_instr();
	endtask

	task impl(input logic [7:0] opc);
		open_instr(2);
		put(pc, opc);
		pc = pc + 16'd1;
		case (opc)
			8'haa: rx = ra;
			8'h8a: ra = rx;
			8'he8: rx = rx + 8'd1;
			8'hca: rx = rx - 8'd1;
			8'hc8: ry = ry + 8'd1;
			8'h88: ry = ry - 8'd1;
			8'h18: fc = 1'b0;
			default: fc = 1'b1;
		endcase
		if (opc == 8'h8a)
			set_nz(ra);
		else if (opc == 8'haa || opc == 8'he8 || opc == 8'hca)
			set_nz(rx);
		else if (opc == 8'hc8 || opc == 8'h88)
			set_nz(ry);
		close_instr();
	endtask

	task branch(input logic [7:0] opc, input logic [15:0] target);
		logic taken;
		logic [15:0] off;
		off = target - pc - 16'd2;
		case (opc)
			8'h90: taken = !fc;
			8'hb0: taken = fc;
			8'hd0: taken = !fz;
			default: taken = fz;
		endcase
		open_instr(taken ? 3 : 2);
		put(pc, opc);
		put(pc + 16'd1, off[7:0]);
		pc = taken ? target : pc + 16'd2;
		close_instr();
	endtask

	task jmp(input logic [15:0] target);
		open_instr(3);
		put(pc, 8'h4c);
		put(pc + 16'd1, target[7:0]);
		put(pc + 16'd2, target[15:8]);
		pc = target;
		close_instr();
	endtask

	task build_program;
		logic [15:0] loop;
		pc = 16'h8000;
		ra = 8'h00;
		rx = 8'h00;
		ry = 8'h00;
		{fn, fv, fz, fc} = 4'b0000;
		close_instr();
		// alu with random immediates
		imm(8'ha9, lcg_byte());
		store(8'h85, 16'h0010);
		impl(8'h38);
		imm(8'h69, lcg_byte());
		store(8'h85, 16'h0011);
		impl(8'h18);
		imm(8'h69, lcg_byte());
		store(8'h85, 16'h0012);
		imm(8'h29, lcg_byte());
		store(8'h85, 16'h0013);
		imm(8'h09, lcg_byte());
		store(8'h85, 16'h0014);
		imm(8'h49, lcg_byte());
		store(8'h85, 16'h0015);
		imm(8'hc9, lcg_byte());
		store(8'h85, 16'h0016);
		// round trip through memory
		imm(8'ha2, lcg_byte());
		store(8'h8e, 16'h0345);
		load_abs(8'hac, 16'h0345);
		store(8'h84, 16'h0020);
		// implied group
		imm(8'ha9, lcg_byte());
		impl(8'haa);
		impl(8'he8);
		impl(8'hca);
		impl(8'hc8);
		impl(8'h88);
		impl(8'h8a);
		impl(8'h18);
		impl(8'h38);
		store(8'h85, 16'h0021);
		// countdown loop
		imm(8'ha2, 8'h03);
		loop = pc;
		repeat (3)
		begin
			impl(8'hca);
			branch(8'hd0, loop);
		end
		branch(8'hf0, pc + 16'd6);
		branch(8'hd0, pc + 16'd6);
		// x leaves zero so beq falls through
		impl(8'he8);
		branch(8'hf0, pc + 16'd6);
		impl(8'h38);
		branch(8'h90, pc + 16'd6);
		branch(8'hb0, pc + 16'd6);
		impl(8'h18);
		branch(8'hb0, pc + 16'd6);
		branch(8'h90, pc + 16'd6);
		// page crossings forward and backward
		jmp(16'h81f8);
		impl(8'h38);
		branch(8'hb0, 16'h8210);
		impl(8'h18);
		branch(8'h90, 16'h81f0);
		repeat (2)
			jmp(pc);
	endtask

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (n_reset && sync)
		begin
			fetch_cnt <= fetch_cnt + 1;
			since_fetch <= 1;
		end
		else
			since_fetch <= since_fetch + 1;
		if (n_reset && !rw)
			store_cnt <= store_cnt + 1;
		if (cpu_inst.cpu_assert_inst.fail_cnt != 0)
		begin
			$display("a bus protocol assertion inside the cpu failed");
			report_fail();
		end
		else if (cycle_cnt > cycle_limit)
		begin
			$display("timeout: the program did not reach its last fetch");
			report_fail();
		end
	end

	reset_fetch: assert property (@(posedge clk) disable iff (!n_reset)
		sync && fetch_cnt == 0 |-> adr == 16'h8000 && rw && dbg_p == 8'h3c)
	else
	begin
		$display("Fail first fetch: adr %h rw %h dbg_p %h",
			$sampled(adr), $sampled(rw), $sampled(dbg_p));
		report_fail();
	end

	fetch_adr: assert property (@(posedge clk) disable iff (!n_reset)
		sync |-> adr == exp_fetch[fetch_cnt])
	else
	begin
		$display("Fail adr: expected %h, got %h",
			exp_fetch[$sampled(fetch_cnt)], $sampled(adr));
		report_fail();
	end

	fetch_pc: assert property (@(posedge clk) disable iff (!n_reset)
		sync |-> dbg_pc == exp_fetch[fetch_cnt])
	else
	begin
		$display("Fail dbg_pc: expected %h, got %h",
			exp_fetch[$sampled(fetch_cnt)], $sampled(dbg_pc));
		report_fail();
	end

	fetch_gap: assert property (@(posedge clk) disable iff (!n_reset)
		sync && fetch_cnt > 0 |-> since_fetch == exp_gap[fetch_cnt-1])
	else
	begin
		$display("Fail fetch gap at %h: expected %h cycles, got %h",
			$sampled(adr), exp_gap[$sampled(fetch_cnt)-1], $sampled(since_fetch));
		report_fail();
	end

	reg_a: assert property (@(posedge clk) disable iff (!n_reset)
		$past(sync) && fetch_cnt > 0 |-> dbg_a == exp_a[fetch_cnt-1])
	else
	begin
		$display("Fail dbg_a: expected %h, got %h", exp_a[fetch_cnt-1], $sampled(dbg_a));
		report_fail();
	end

	reg_x: assert property (@(posedge clk) disable iff (!n_reset)
		$past(sync) && fetch_cnt > 0 |-> dbg_x == exp_x[fetch_cnt-1])
	else
	begin
		$display("Fail dbg_x: expected %h, got %h", exp_x[fetch_cnt-1], $sampled(dbg_x));
		report_fail();
	end

	reg_y: assert property (@(posedge clk) disable iff (!n_reset)
		$past(sync) && fetch_cnt > 0 |-> dbg_y == exp_y[fetch_cnt-1])
	else
	begin
		$display("Fail dbg_y: expected %h, got %h", exp_y[fetch_cnt-1], $sampled(dbg_y));
		report_fail();
	end

	reg_p: assert property (@(posedge clk) disable iff (!n_reset)
		$past(sync) && fetch_cnt > 0 |-> dbg_p == exp_p[fetch_cnt-1])
	else
	begin
		$display("Fail dbg_p: expected %h, got %h", exp_p[fetch_cnt-1], $sampled(dbg_p));
		report_fail();
	end

	store_bus: assert property (@(posedge clk) disable iff (!n_reset)
		!rw |-> adr == exp_store_adr[store_cnt] && data_out == exp_store_val[store_cnt])
	else
	begin
		$display("Fail store adr %h data_out %h: expected %h and %h",
			$sampled(adr), $sampled(data_out),
			exp_store_adr[$sampled(store_cnt)], exp_store_val[$sampled(store_cnt)]);
		report_fail();
	end

	initial
	begin
		n_reset = 1'b0;
		lcg_state = 32'h573169a2;
		for (int i = 0; i < 65536; i++)
			mem[i] = fill_byte(i[15:0]);
		build_program();
		cycle_limit = 4 * total_cycles + 50;
		repeat (2) @(posedge clk);
		#1 n_reset = 1'b1;
		wait (fetch_cnt == n_fetch);
		repeat (2) @(posedge clk);
		if (store_cnt == n_store)
		begin
			$display("TB PASSED");
			$finish;
		end
		else
		begin
			$display("store count wrong: saw %0d stores, expected %0d", store_cnt, n_store);
			report_fail();
		end
	end

endmodule

`default_nettype wire
